// File: project.f
rtl/nes_video_pkg.sv
rtl/ppu_reg_port.sv
rtl/ppu_ctrl.sv
rtl/ppu_vram.sv
rtl/ppu_pixel_gen.sv
rtl/nes_video.sv
test/tb_clock.sv
test/tb_nes_video.sv

// File: test/tb_nes_video.sv
`timescale 1ns/10ps

module tb_nes_video;

    localparam int TIMEOUT  = 5000;
    localparam int N_BURSTS = 6;

    logic                    clk_ppu;
    logic                    arst_n;
    logic [1:0]              cpu_phase;
    logic                    cpu_cs;
    logic                    cpu_rw;
    nes_video_pkg::reg_sel_t cpu_addr;
    nes_video_pkg::byte_t    cpu_wdata;
    nes_video_pkg::byte_t    cpu_rdata;
    logic                    nmi;
    logic                    vblank;
    nes_video_pkg::pixel_t   pixel;
    logic                    pixel_en;

    // ******************************
    // Reference model state
    // ******************************
    nes_video_pkg::byte_t      nt_m      [nes_video_pkg::NT_SIZE];
    nes_video_pkg::pixel_t     pal_m     [nes_video_pkg::PAL_SIZE];
    bit                        nt_known  [nes_video_pkg::NT_SIZE];
    bit                        pal_known [nes_video_pkg::PAL_SIZE];
    nes_video_pkg::byte_t      ctrl_m;
    nes_video_pkg::byte_t      buf_m;
    bit                        buf_known;
    bit                        latch_m;
    nes_video_pkg::byte_t      addr_hi_m;
    nes_video_pkg::vram_addr_t vaddr_m;

    nes_video_pkg::vram_addr_t burst_addr [N_BURSTS];
    logic                      burst_row  [N_BURSTS];
    int                        burst_len  [N_BURSTS];

    logic [31:0] rng_state;
    int          byte_errs;
    int          pixel_errs;
    int          bit_errs;
    int          timeouts;

    tb_clock i_tb_clock (
        .clk_o    (clk_ppu),
        .arst_n_o (arst_n)
    );

    nes_video i_nes_video (
        .clk_ppu     (clk_ppu),
        .arst_n_i    (arst_n),
        .cpu_phase_i (cpu_phase),
        .cpu_cs_i    (cpu_cs),
        .cpu_rw_i    (cpu_rw),
        .cpu_addr_i  (cpu_addr),
        .cpu_data_i  (cpu_wdata),
        .cpu_data_o  (cpu_rdata),
        .nmi_o       (nmi),
        .vblank_o    (vblank),
        .pixel_o     (pixel),
        .pixel_en_o  (pixel_en)
    );

    always @(posedge clk_ppu) begin
        #1 cpu_phase = (cpu_phase == 2'd2) ? 2'd0 : cpu_phase + 2'd1;   // 0, 1, 2
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic mem_known(input nes_video_pkg::vram_addr_t a);
        if (a >= nes_video_pkg::PAL_BASE) begin
            return pal_known[a % nes_video_pkg::PAL_SIZE];
        end
        if (a >= nes_video_pkg::NT_BASE) begin
            return nt_known[a % nes_video_pkg::NT_SIZE];
        end
        return 1'b1;
    endfunction

    function automatic nes_video_pkg::byte_t mem_read(input nes_video_pkg::vram_addr_t a);
        if (a >= nes_video_pkg::PAL_BASE) begin
            return pal_m[a % nes_video_pkg::PAL_SIZE];
        end
        if (a >= nes_video_pkg::NT_BASE) begin
            return nt_m[a % nes_video_pkg::NT_SIZE];
        end
        return 8'h00;       // Nothing below the nametable
    endfunction

    task automatic mem_write(input nes_video_pkg::vram_addr_t a, input nes_video_pkg::byte_t d);
        if (a >= nes_video_pkg::PAL_BASE) begin
            pal_m[a % nes_video_pkg::PAL_SIZE]     = d;
            pal_known[a % nes_video_pkg::PAL_SIZE] = 1'b1;
        end else if (a >= nes_video_pkg::NT_BASE) begin
            nt_m[a % nes_video_pkg::NT_SIZE]     = d;
            nt_known[a % nes_video_pkg::NT_SIZE] = 1'b1;
        end
    endtask

    function automatic nes_video_pkg::vram_addr_t next_addr(input nes_video_pkg::vram_addr_t a);
        return a + (ctrl_m[2] ? 14'd32 : 14'd1);
    endfunction

    // ******************************
    // Compare tasks
    // ******************************
    task automatic check_byte(input string name, input nes_video_pkg::byte_t want,
                              input nes_video_pkg::byte_t got);
        if (got !== want) begin
            byte_errs++;
            $display("FAIL %s: expected 0x%02h, actual 0x%02h", name, want, got);
        end
    endtask

    task automatic check_pixel(input string name, input nes_video_pkg::pixel_t want,
                               input nes_video_pkg::pixel_t got);
        if (got !== want) begin
            pixel_errs++;
            $display("FAIL %s: expected 0x%02h, actual 0x%02h", name, want, got);
        end
    endtask

    task automatic check_bit(input string name, input logic want, input logic got);
        if (got !== want) begin
            bit_errs++;
            $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, want, got);
        end
    endtask

    // ******************************
    // CPU side
    // ******************************
    task automatic cpu_access(input logic rw, input nes_video_pkg::reg_sel_t sel,
                              input nes_video_pkg::byte_t wdata, input logic [1:0] phase,
                              output nes_video_pkg::byte_t rdata);
        logic [1:0] prev;
        int         n;
        prev = (phase == 2'd0) ? 2'd2 : phase - 2'd1;
        n    = 0;
        do begin
            @(posedge clk_ppu);
            n++;
        end while (cpu_phase != prev && n < TIMEOUT);  // Requested phase follows
        if (cpu_phase != prev) begin
            timeouts++;
            $display("Timeout: CPU phase %0d never came", phase);
        end
        #1;
        cpu_cs    = 1'b1;
        cpu_rw    = rw;
        cpu_addr  = sel;
        cpu_wdata = wdata;
        @(negedge clk_ppu);
        rdata = cpu_rdata;
        @(posedge clk_ppu);
        #1;
        cpu_cs = 1'b0;
    endtask

    task automatic reg_write(input nes_video_pkg::reg_sel_t sel, input nes_video_pkg::byte_t d);
        nes_video_pkg::byte_t ignored;
        cpu_access(1'b0, sel, d, 2'd2, ignored);
        case (sel)
            nes_video_pkg::REG_CTRL: ctrl_m = d;
            nes_video_pkg::REG_ADDR: begin
                if (latch_m) begin
                    vaddr_m = {addr_hi_m[5:0], d};
                end else begin
                    addr_hi_m = d;
                end
                latch_m = !latch_m;
            end
            nes_video_pkg::REG_DATA: begin
                mem_write(vaddr_m, d);
                vaddr_m = next_addr(vaddr_m);
            end
            default: ;
        endcase
    endtask

    task automatic status_read(output nes_video_pkg::byte_t d);
        cpu_access(1'b1, nes_video_pkg::REG_STATUS, 8'h00, 2'd2, d);
        latch_m = 1'b0;
    endtask

    task automatic data_read_check();
        nes_video_pkg::byte_t d;
        cpu_access(1'b1, nes_video_pkg::REG_DATA, 8'h00, 2'd2, d);
        if (buf_known) begin
            check_byte("cpu_data_o", buf_m, d);
        end
        buf_known = mem_known(vaddr_m);
        buf_m     = mem_read(vaddr_m);
        vaddr_m   = next_addr(vaddr_m);
    endtask

    task automatic set_addr(input nes_video_pkg::vram_addr_t a);
        logic [31:0] r;
        r = rand32();
        reg_write(nes_video_pkg::REG_ADDR, {r[1:0], a[13:8]});     // Top bits are don't care
        reg_write(nes_video_pkg::REG_ADDR, a[7:0]);
    endtask

    task automatic wait_vblank(input logic level);
        int n;
        n = 0;
        do begin
            @(negedge clk_ppu);
            n++;
        end while (vblank !== level && n < TIMEOUT);
        if (vblank !== level) begin
            timeouts++;
            $display("Timeout: vblank_o never became %0b", level);
        end
    endtask

    task automatic write_burst(input int idx);
        logic [31:0]               r;
        nes_video_pkg::vram_addr_t a;
        r = rand32();
        case (r[1:0])
            2'd0: a = nes_video_pkg::NT_BASE + nes_video_pkg::vram_addr_t'(r[31:8] % 1024);
            2'd1: a = nes_video_pkg::PAL_BASE + nes_video_pkg::vram_addr_t'(r[31:8] % 32);
            2'd2: a = 14'h2400 + nes_video_pkg::vram_addr_t'(r[31:8] % 32'h1B00);   // Mirrors
            default: a = nes_video_pkg::vram_addr_t'(r[31:8] % 32'h2000);
        endcase
        burst_addr[idx] = a;
        burst_row[idx]  = idx[0];
        burst_len[idx]  = 1 + int'(r[7:4]);
        reg_write(nes_video_pkg::REG_CTRL, {5'b0, burst_row[idx], 2'b0});
        set_addr(a);
        for (int i = 0; i < burst_len[idx]; i++) begin
            r = rand32();
            reg_write(nes_video_pkg::REG_DATA, r[7:0]);
        end
    endtask

    task automatic check_frame();
        int                    count;
        int                    n;
        int                    x;
        int                    y;
        bit                    extra;
        nes_video_pkg::pixel_t want;
        wait_vblank(1'b1);
        wait_vblank(1'b0);
        count = 0;
        n     = 0;
        while (count < nes_video_pkg::VISIBLE_DOTS * nes_video_pkg::VISIBLE_LINES
               && n < TIMEOUT) begin
            @(negedge clk_ppu);
            n++;
            if (pixel_en === 1'b1) begin
                x    = count % nes_video_pkg::VISIBLE_DOTS;
                y    = count / nes_video_pkg::VISIBLE_DOTS;
                want = pal_m[nt_m[(y / 8) * nes_video_pkg::TILES_PER_ROW + x / 8][4:0]];
                check_pixel("pixel_o", want, pixel);
                count++;
            end
        end
        if (count < nes_video_pkg::VISIBLE_DOTS * nes_video_pkg::VISIBLE_LINES) begin
            timeouts++;
            $display("Timeout: only %0d pixels came out", count);
        end
        extra = 1'b0;
        n     = 0;
        while (vblank !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk_ppu);
            n++;
            if (vblank !== 1'b1 && pixel_en === 1'b1) extra = 1'b1;
        end
        if (vblank !== 1'b1) begin
            timeouts++;
            $display("Timeout: vblank_o did not rise after the last pixel");
        end
        check_bit("pixel_en_o after last pixel", 1'b0, extra);
    endtask

    initial begin
        nes_video_pkg::byte_t    d;
        nes_video_pkg::reg_sel_t sel;
        logic [31:0]             r;
        int                      n;
        bit                      seen;
        cpu_phase = 2'd0;
        cpu_cs    = 1'b0;
        cpu_rw    = 1'b1;
        cpu_addr  = '0;
        cpu_wdata = '0;
        rng_state = 32'h7f33_242c;
        ctrl_m    = '0;
        latch_m   = 1'b0;
        vaddr_m   = '0;
        buf_known = 1'b0;
        byte_errs  = 0;
        pixel_errs = 0;
        bit_errs   = 0;
        timeouts   = 0;

        n = 0;
        while (arst_n !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk_ppu);
            n++;
        end
        if (arst_n !== 1'b1) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end
        @(negedge clk_ppu);
        check_bit("pixel_en_o", 1'b0, pixel_en);
        check_bit("nmi_o", 1'b0, nmi);
        check_bit("vblank_o", 1'b0, vblank);
        status_read(d);
        check_byte("cpu_data_o", 8'h00, d);

        // Unused register numbers read zero
        for (int i = 0; i < 8; i++) begin
            sel = nes_video_pkg::reg_sel_t'(i);
            if (sel != nes_video_pkg::REG_CTRL && sel != nes_video_pkg::REG_STATUS
                && sel != nes_video_pkg::REG_ADDR && sel != nes_video_pkg::REG_DATA) begin
                r = rand32();
                reg_write(sel, r[7:0]);
                cpu_access(1'b1, sel, 8'h00, 2'd2, d);
                check_byte("cpu_data_o", 8'h00, d);
            end
        end

        // Palette and visible tiles within one vblank
        wait_vblank(1'b1);
        reg_write(nes_video_pkg::REG_CTRL, 8'h00);
        set_addr(nes_video_pkg::PAL_BASE);
        repeat (nes_video_pkg::PAL_SIZE) begin
            r = rand32();
            reg_write(nes_video_pkg::REG_DATA, r[7:0]);
        end
        set_addr(nes_video_pkg::NT_BASE);
        repeat (12) begin
            r = rand32();
            reg_write(nes_video_pkg::REG_DATA, r[7:0]);
        end

        for (int i = 0; i < N_BURSTS; i++) begin
            wait_vblank(1'b0);
            wait_vblank(1'b1);
            write_burst(i);
        end
        for (int i = 0; i < N_BURSTS; i++) begin
            reg_write(nes_video_pkg::REG_CTRL, {5'b0, burst_row[i], 2'b0});
            set_addr(burst_addr[i]);
            repeat (burst_len[i] + 1) data_read_check();
        end

        check_frame();

        // STATUS flag and address latch reset
        wait_vblank(1'b1);
        cpu_access(1'b1, nes_video_pkg::REG_STATUS, 8'h00, 2'd1, d);  // Wrong phase, no effect
        status_read(d);
        check_byte("cpu_data_o", 8'h80, d);
        status_read(d);
        check_byte("cpu_data_o", 8'h00, d);
        r = rand32();
        reg_write(nes_video_pkg::REG_CTRL, 8'h00);
        reg_write(nes_video_pkg::REG_ADDR, r[7:0]);
        status_read(d);
        set_addr(nes_video_pkg::NT_BASE + 14'd5);
        data_read_check();
        data_read_check();

        // NMI enabled, then disabled for a whole frame
        wait_vblank(1'b0);
        reg_write(nes_video_pkg::REG_CTRL, 8'h80);
        @(negedge clk_ppu);
        check_bit("nmi_o", 1'b0, nmi);
        wait_vblank(1'b1);
        check_bit("nmi_o", 1'b1, nmi);
        status_read(d);
        check_byte("cpu_data_o", 8'h80, d);
        @(negedge clk_ppu);
        check_bit("nmi_o", 1'b0, nmi);
        reg_write(nes_video_pkg::REG_CTRL, 8'h00);
        seen = 1'b0;
        repeat (nes_video_pkg::DOTS_PER_LINE * nes_video_pkg::LINES_PER_FRAME + 100) begin
            @(negedge clk_ppu);
            if (nmi !== 1'b0) seen = 1'b1;
        end
        check_bit("nmi_o with NMI disabled", 1'b0, seen);

        $display("Errors: byte %0d, pixel %0d, bit %0d, timeout %0d",
                 byte_errs, pixel_errs, bit_errs, timeouts);
        if (byte_errs + pixel_errs + bit_errs + timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;      // 10 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        #1 arst_n_o = 1'b1;
    end

endmodule

// File: rtl/nes_video.sv
`timescale 1ns/10ps

module nes_video (
    input  logic                    clk_ppu,
    input  logic                    arst_n_i,
    input  logic [1:0]              cpu_phase_i,
    input  logic                    cpu_cs_i,
    input  logic                    cpu_rw_i,
    input  nes_video_pkg::reg_sel_t cpu_addr_i,
    input  nes_video_pkg::byte_t    cpu_data_i,
    output nes_video_pkg::byte_t    cpu_data_o,
    output logic                    nmi_o,
    output logic                    vblank_o,
    output nes_video_pkg::pixel_t   pixel_o,
    output logic                    pixel_en_o
);

    // ******************************
    // Internal wiring
    // ******************************
    logic                             vram_req;
    logic                             vram_req_we;
    nes_video_pkg::vram_addr_t        vram_req_addr;
    nes_video_pkg::byte_t             vram_req_wdata;
    logic                             vram_grant;
    logic                             ctrl_nmi_en;
    logic                             status_read;
    logic                             vblank_flag;
    nes_video_pkg::vram_addr_t        bus_addr;
    logic                             bus_we;
    nes_video_pkg::byte_t             bus_wdata;
    nes_video_pkg::byte_t             bus_rdata;
    logic                             fetch_strobe;
    logic                             visible;
    logic [nes_video_pkg::PAL_AW-1:0] pal_addr;
    nes_video_pkg::pixel_t            pal_rdata;

    ppu_reg_port i_ppu_reg_port (
        .clk_ppu          (clk_ppu),
        .arst_n_i         (arst_n_i),
        .cpu_phase_i      (cpu_phase_i),
        .cpu_cs_i         (cpu_cs_i),
        .cpu_rw_i         (cpu_rw_i),
        .cpu_addr_i       (cpu_addr_i),
        .cpu_data_i       (cpu_data_i),
        .cpu_data_o       (cpu_data_o),
        .vblank_flag_i    (vblank_flag),
        .vram_grant_i     (vram_grant),
        .vram_rdata_i     (bus_rdata),
        .vram_req_o       (vram_req),
        .vram_req_we_o    (vram_req_we),
        .vram_req_addr_o  (vram_req_addr),
        .vram_req_wdata_o (vram_req_wdata),
        .ctrl_nmi_en_o    (ctrl_nmi_en),
        .status_read_o    (status_read)
    );

    ppu_ctrl i_ppu_ctrl (
        .clk_ppu          (clk_ppu),
        .arst_n_i         (arst_n_i),
        .vram_req_i       (vram_req),
        .vram_req_we_i    (vram_req_we),
        .vram_req_addr_i  (vram_req_addr),
        .vram_req_wdata_i (vram_req_wdata),
        .ctrl_nmi_en_i    (ctrl_nmi_en),
        .status_read_i    (status_read),
        .vram_grant_o     (vram_grant),
        .vblank_flag_o    (vblank_flag),
        .bus_addr_o       (bus_addr),
        .bus_we_o         (bus_we),
        .bus_wdata_o      (bus_wdata),
        .fetch_strobe_o   (fetch_strobe),
        .visible_o        (visible),
        .vblank_o         (vblank_o),
        .nmi_o            (nmi_o)
    );

    ppu_vram i_ppu_vram (
        .clk_ppu     (clk_ppu),
        .bus_addr_i  (bus_addr),
        .bus_we_i    (bus_we),
        .bus_wdata_i (bus_wdata),
        .bus_rdata_o (bus_rdata),
        .pal_addr_i  (pal_addr),
        .pal_rdata_o (pal_rdata)
    );

    ppu_pixel_gen i_ppu_pixel_gen (
        .clk_ppu        (clk_ppu),
        .arst_n_i       (arst_n_i),
        .fetch_strobe_i (fetch_strobe),
        .visible_i      (visible),
        .bus_rdata_i    (bus_rdata),
        .pal_addr_o     (pal_addr),
        .pal_rdata_i    (pal_rdata),
        .pixel_o        (pixel_o),
        .pixel_en_o     (pixel_en_o)
    );

endmodule

// File: rtl/ppu_pixel_gen.sv
`timescale 1ns/10ps

module ppu_pixel_gen (
    input  logic                              clk_ppu,
    input  logic                              arst_n_i,
    input  logic                              fetch_strobe_i,
    input  logic                              visible_i,
    input  nes_video_pkg::byte_t              bus_rdata_i,
    output logic [nes_video_pkg::PAL_AW-1:0]  pal_addr_o,
    input  nes_video_pkg::pixel_t             pal_rdata_i,
    output nes_video_pkg::pixel_t             pixel_o,
    output logic                              pixel_en_o
);

    logic                 fetch_d1_q;
    logic                 visible_d1_q;
    nes_video_pkg::byte_t tile_q;
    nes_video_pkg::byte_t tile;

    // New tile byte is used in the cycle it returns
    assign tile       = fetch_d1_q ? bus_rdata_i : tile_q;
    assign pal_addr_o = tile[nes_video_pkg::PAL_AW-1:0];

    // ******************************
    // Pipeline control
    // ******************************
    always_ff @(posedge clk_ppu or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_d1_q   <= 1'b0;
            visible_d1_q <= 1'b0;
            pixel_en_o   <= 1'b0;
        end else begin
            fetch_d1_q   <= fetch_strobe_i;    // Aligns with VRAM read latency
            visible_d1_q <= visible_i;
            pixel_en_o   <= visible_d1_q;
        end
    end

    always_ff @(posedge clk_ppu) begin
        if (fetch_d1_q) begin
            tile_q <= bus_rdata_i;
        end
        if (visible_d1_q) begin
            pixel_o <= pal_rdata_i;
        end
    end

endmodule

// File: rtl/ppu_vram.sv
`timescale 1ns/10ps

module ppu_vram (
    input  logic                              clk_ppu,
    input  nes_video_pkg::vram_addr_t         bus_addr_i,
    input  logic                              bus_we_i,
    input  nes_video_pkg::byte_t              bus_wdata_i,
    output nes_video_pkg::byte_t              bus_rdata_o,
    input  logic [nes_video_pkg::PAL_AW-1:0]  pal_addr_i,
    output nes_video_pkg::pixel_t             pal_rdata_o
);

    nes_video_pkg::byte_t  nt_mem  [nes_video_pkg::NT_SIZE];
    nes_video_pkg::pixel_t pal_mem [nes_video_pkg::PAL_SIZE];

    logic                             is_pal;
    logic                             is_nt;
    logic [nes_video_pkg::NT_AW-1:0]  nt_idx;
    logic [nes_video_pkg::PAL_AW-1:0] pal_idx;

    // ******************************
    // Address decode
    // ******************************
    assign is_pal  = bus_addr_i >= nes_video_pkg::PAL_BASE;
    assign is_nt   = (bus_addr_i >= nes_video_pkg::NT_BASE) && !is_pal;
    assign nt_idx  = bus_addr_i[nes_video_pkg::NT_AW-1:0];     // Mirrors every 1 KiB
    assign pal_idx = bus_addr_i[nes_video_pkg::PAL_AW-1:0];

    always_ff @(posedge clk_ppu) begin
        if (bus_we_i && is_nt) begin
            nt_mem[nt_idx] <= bus_wdata_i;
        end
        if (bus_we_i && is_pal) begin
            pal_mem[pal_idx] <= bus_wdata_i;
        end
        if (is_pal) begin
            bus_rdata_o <= pal_mem[pal_idx];
        end else if (is_nt) begin
            bus_rdata_o <= nt_mem[nt_idx];
        end else begin
            bus_rdata_o <= '0;                  // Pattern space not present
        end
    end

    assign pal_rdata_o = pal_mem[pal_addr_i];

endmodule

// File: rtl/ppu_ctrl.sv
`timescale 1ns/10ps

module ppu_ctrl (
    input  logic                      clk_ppu,
    input  logic                      arst_n_i,
    input  logic                      vram_req_i,
    input  logic                      vram_req_we_i,
    input  nes_video_pkg::vram_addr_t vram_req_addr_i,
    input  nes_video_pkg::byte_t      vram_req_wdata_i,
    input  logic                      ctrl_nmi_en_i,
    input  logic                      status_read_i,
    output logic                      vram_grant_o,
    output logic                      vblank_flag_o,
    output nes_video_pkg::vram_addr_t bus_addr_o,
    output logic                      bus_we_o,
    output nes_video_pkg::byte_t      bus_wdata_o,
    output logic                      fetch_strobe_o,
    output logic                      visible_o,
    output logic                      vblank_o,
    output logic                      nmi_o
);

    nes_video_pkg::ctrl_state_t state_q;
    nes_video_pkg::ctrl_state_t state_d;
    nes_video_pkg::dot_t        dot_q;
    nes_video_pkg::line_t       line_q;
    logic                       vblank_flag_q;

    logic                       dot_last;
    logic                       line_last;
    logic                       vblank_start;
    logic                       vblank_end;
    logic                       fetch;
    nes_video_pkg::vram_addr_t  fetch_addr;

    assign dot_last  = dot_q == nes_video_pkg::dot_t'(nes_video_pkg::DOTS_PER_LINE - 1);
    assign line_last = line_q == nes_video_pkg::line_t'(nes_video_pkg::LINES_PER_FRAME - 1);

    // ******************************
    // Line phase FSM
    // ******************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            nes_video_pkg::VISIBLE: begin
                if (dot_q == nes_video_pkg::dot_t'(nes_video_pkg::VISIBLE_DOTS - 1)) begin
                    state_d = nes_video_pkg::POST;
                end
            end
            nes_video_pkg::POST: begin
                if (dot_last) begin
                    if (line_q == nes_video_pkg::line_t'(nes_video_pkg::VISIBLE_LINES - 1)) begin
                        state_d = nes_video_pkg::VBLANK;
                    end else begin
                        state_d = nes_video_pkg::VISIBLE;
                    end
                end
            end
            default: begin
                if (dot_last && line_last) state_d = nes_video_pkg::VISIBLE;
            end
        endcase
    end

    assign vblank_start = (state_q == nes_video_pkg::POST) && (state_d == nes_video_pkg::VBLANK);
    assign vblank_end   = (state_q == nes_video_pkg::VBLANK) && (state_d == nes_video_pkg::VISIBLE);

    always_ff @(posedge clk_ppu or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q       <= nes_video_pkg::VISIBLE;
            dot_q         <= '0;
            line_q        <= '0;
            vblank_flag_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (dot_last) begin
                dot_q  <= '0;
                line_q <= line_last ? '0 : line_q + 1'b1;
            end else begin
                dot_q <= dot_q + 1'b1;
            end
            if (vblank_start) begin
                vblank_flag_q <= 1'b1;
            end else if (status_read_i || vblank_end) begin
                vblank_flag_q <= 1'b0;
            end
        end
    end

    // ******************************
    // VRAM bus arbitration
    // ******************************
    assign fetch = (state_q == nes_video_pkg::VISIBLE) && (dot_q[2:0] == 3'd0);   // Tile start
    assign fetch_addr = nes_video_pkg::NT_BASE
                      + nes_video_pkg::vram_addr_t'(line_q >> 3)
                      * nes_video_pkg::vram_addr_t'(nes_video_pkg::TILES_PER_ROW)
                      + nes_video_pkg::vram_addr_t'(dot_q >> 3);

    assign vram_grant_o = vram_req_i && !fetch;     // Render fetch wins
    assign bus_addr_o   = fetch ? fetch_addr : vram_req_addr_i;
    assign bus_we_o     = vram_grant_o && vram_req_we_i;
    assign bus_wdata_o  = vram_req_wdata_i;

    assign fetch_strobe_o = fetch;
    assign visible_o      = state_q == nes_video_pkg::VISIBLE;
    assign vblank_o       = state_q == nes_video_pkg::VBLANK;
    assign vblank_flag_o  = vblank_flag_q;
    assign nmi_o          = vblank_flag_q && ctrl_nmi_en_i;

endmodule

// File: rtl/ppu_reg_port.sv
`timescale 1ns/10ps

module ppu_reg_port (
    input  logic                      clk_ppu,
    input  logic                      arst_n_i,
    input  logic [1:0]                cpu_phase_i,
    input  logic                      cpu_cs_i,
    input  logic                      cpu_rw_i,
    input  nes_video_pkg::reg_sel_t   cpu_addr_i,
    input  nes_video_pkg::byte_t      cpu_data_i,
    output nes_video_pkg::byte_t      cpu_data_o,
    input  logic                      vblank_flag_i,
    input  logic                      vram_grant_i,
    input  nes_video_pkg::byte_t      vram_rdata_i,
    output logic                      vram_req_o,
    output logic                      vram_req_we_o,
    output nes_video_pkg::vram_addr_t vram_req_addr_o,
    output nes_video_pkg::byte_t      vram_req_wdata_o,
    output logic                      ctrl_nmi_en_o,
    output logic                      status_read_o
);

    nes_video_pkg::byte_t      ctrl_q;
    logic                      latch_q;        // High ADDR byte already written
    logic [5:0]                addr_hi_q;
    nes_video_pkg::vram_addr_t vram_addr_q;
    nes_video_pkg::byte_t      rd_buf_q;
    logic                      rd_pend_q;      // Refill data arrives this cycle
    logic                      req_q;
    logic                      req_we_q;
    nes_video_pkg::vram_addr_t req_addr_q;
    nes_video_pkg::byte_t      req_wdata_q;

    logic                      cpu_acc;
    logic                      cpu_wr;
    logic                      data_acc;
    logic                      addr_wr;
    nes_video_pkg::vram_addr_t addr_step;

    assign cpu_acc  = cpu_cs_i && (cpu_phase_i == nes_video_pkg::CPU_ACCESS_PHASE);
    assign cpu_wr   = cpu_acc && !cpu_rw_i;
    assign data_acc = cpu_acc && (cpu_addr_i == nes_video_pkg::REG_DATA);
    assign addr_wr  = cpu_wr && (cpu_addr_i == nes_video_pkg::REG_ADDR);
    assign status_read_o = cpu_acc && cpu_rw_i && (cpu_addr_i == nes_video_pkg::REG_STATUS);

    assign addr_step = ctrl_q[2] ? nes_video_pkg::vram_addr_t'(nes_video_pkg::VRAM_INC_ROW)
                                 : nes_video_pkg::vram_addr_t'(1);

    // ******************************
    // CPU read mux
    // ******************************
    always_comb begin
        case (cpu_addr_i)
            nes_video_pkg::REG_CTRL:   cpu_data_o = ctrl_q;
            nes_video_pkg::REG_STATUS: cpu_data_o = {vblank_flag_i, 7'b0};
            nes_video_pkg::REG_DATA:   cpu_data_o = rd_pend_q ? vram_rdata_i : rd_buf_q;
            default:                   cpu_data_o = '0;
        endcase
    end

    always_ff @(posedge clk_ppu or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q      <= '0;
            latch_q     <= 1'b0;
            vram_addr_q <= '0;
        end else begin
            if (cpu_wr && (cpu_addr_i == nes_video_pkg::REG_CTRL)) begin
                ctrl_q <= cpu_data_i;
            end
            if (status_read_o) begin
                latch_q <= 1'b0;
            end else if (addr_wr) begin
                latch_q <= !latch_q;
                if (latch_q) begin
                    vram_addr_q <= {addr_hi_q, cpu_data_i};   // Low byte completes the pair
                end
            end
            if (data_acc) begin
                vram_addr_q <= vram_addr_q + addr_step;
            end
        end
    end

    // ******************************
    // VRAM requests
    // ******************************
    always_ff @(posedge clk_ppu or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q     <= 1'b0;
            rd_pend_q <= 1'b0;
        end else begin
            if (data_acc) begin
                req_q <= 1'b1;
            end else if (vram_grant_i) begin
                req_q <= 1'b0;
            end
            rd_pend_q <= vram_grant_i && !req_we_q;
        end
    end

    always_ff @(posedge clk_ppu) begin
        if (addr_wr && !latch_q) begin
            addr_hi_q <= cpu_data_i[5:0];
        end
        if (data_acc) begin
            req_we_q    <= !cpu_rw_i;
            req_addr_q  <= vram_addr_q;
            req_wdata_q <= cpu_data_i;
        end
        if (rd_pend_q) begin
            rd_buf_q <= vram_rdata_i;
        end
    end

    assign vram_req_o       = req_q;
    assign vram_req_we_o    = req_we_q;
    assign vram_req_addr_o  = req_addr_q;
    assign vram_req_wdata_o = req_wdata_q;
    assign ctrl_nmi_en_o    = ctrl_q[7];

endmodule

// File: rtl/nes_video_pkg.sv
package nes_video_pkg;

    // ******************************
    // Types
    // ******************************
    typedef logic [7:0]  byte_t;
    typedef logic [13:0] vram_addr_t;
    typedef logic [2:0]  reg_sel_t;
    typedef logic [7:0]  pixel_t;
    typedef logic [5:0]  dot_t;
    typedef logic [4:0]  line_t;

    // Phase of the current line, or the whole blanking period
    typedef enum logic [1:0] {
        VISIBLE,    // Visible line, active dots
        POST,       // Visible line, horizontal blank
        VBLANK
    } ctrl_state_t;

    // ******************************
    // Frame timing
    // ******************************
    localparam int DOTS_PER_LINE   = 40;
    localparam int VISIBLE_DOTS    = 32;
    localparam int LINES_PER_FRAME = 30;
    localparam int VISIBLE_LINES   = 24;
    localparam int TILES_PER_ROW   = 4;

    // CPU register numbers
    localparam reg_sel_t REG_CTRL   = 3'd0;
    localparam reg_sel_t REG_STATUS = 3'd2;
    localparam reg_sel_t REG_ADDR   = 3'd6;
    localparam reg_sel_t REG_DATA   = 3'd7;

    localparam logic [1:0] CPU_ACCESS_PHASE = 2'd2;
    localparam int VRAM_INC_ROW = 32;           // Address step with CTRL bit 2 set

    // ******************************
    // Memory map
    // ******************************
    localparam vram_addr_t NT_BASE  = 14'h2000;
    localparam vram_addr_t PAL_BASE = 14'h3F00;
    localparam int NT_SIZE  = 1024;
    localparam int PAL_SIZE = 32;
    localparam int NT_AW    = $clog2(NT_SIZE);
    localparam int PAL_AW   = $clog2(PAL_SIZE);

endpackage
